/* hw/decodePkg.sv */
// Decode package.
// Shared widths, opcode values and control encodings used by the RV64
// instruction-decode stage and its sub-blocks.

package decodePkg;

    typedef logic [63:0] xlen_t;   // register and pc width.
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [11:0] csrIdx_t;
    typedef logic [4:0]  aluOp_t;
    typedef logic [2:0]  immFmt_t;
    typedef logic [3:0]  branch_t;
    typedef logic [2:0]  memOp_t;  // funct3 of the load or store.
    typedef logic [1:0]  mulOp_t;  // funct3[1:0] of the multiply.
    typedef logic [2:0]  csrOp_t;  // funct3 of the csr instruction.
    typedef logic [1:0]  srcB_t;

    // base opcodes, instr[6:0].
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opImm32  = 7'b0011011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opReg32  = 7'b0111011;
    localparam logic [6:0] opSystem = 7'b1110011;

    localparam immFmt_t fmtI = 3'd0;
    localparam immFmt_t fmtS = 3'd1;
    localparam immFmt_t fmtB = 3'd2;
    localparam immFmt_t fmtU = 3'd3;
    localparam immFmt_t fmtJ = 3'd4;

    localparam branch_t brNone = 4'd0;
    localparam branch_t brJal  = 4'd1;
    localparam branch_t brJalr = 4'd2;
    localparam branch_t brEq   = 4'd4;
    localparam branch_t brNe   = 4'd5;
    localparam branch_t brLt   = 4'd6;
    localparam branch_t brGe   = 4'd7;
    localparam branch_t brLtu  = 4'd8;
    localparam branch_t brGeu  = 4'd9;

    // word variants set bit 4 on top of the 64-bit code.
    localparam aluOp_t aluAdd   = 5'd0;
    localparam aluOp_t aluSub   = 5'd1;
    localparam aluOp_t aluSll   = 5'd2;
    localparam aluOp_t aluSlt   = 5'd3;
    localparam aluOp_t aluSltu  = 5'd4;
    localparam aluOp_t aluXor   = 5'd5;
    localparam aluOp_t aluSrl   = 5'd6;
    localparam aluOp_t aluSra   = 5'd7;
    localparam aluOp_t aluOr    = 5'd8;
    localparam aluOp_t aluAnd   = 5'd9;
    localparam aluOp_t aluCopyB = 5'd10;
    localparam aluOp_t aluMul   = 5'd11;
    localparam aluOp_t aluAddw  = 5'd16;
    localparam aluOp_t aluSubw  = 5'd17;
    localparam aluOp_t aluSllw  = 5'd18;
    localparam aluOp_t aluSrlw  = 5'd22;
    localparam aluOp_t aluSraw  = 5'd23;
    localparam aluOp_t aluMulw  = 5'd27;

    localparam srcB_t srcBReg  = 2'b00;
    localparam srcB_t srcBImm  = 2'b01;
    localparam srcB_t srcBFour = 2'b10;

    localparam csrOp_t  csrOpWrite  = 3'b001;  // same code as CSRRW.
    localparam csrIdx_t csrMcause   = 12'h342;
    localparam regIdx_t ecallArgReg = 5'd17;   // a7 carries the ecall number.

endpackage

/* hw/controlDecoder.sv */
// Control decoder.
// Turns opcode, funct3 and funct7 into the control codes of the later stages,
// the immediate format and the branch kind. Unknown encodings raise the
// illegal flag and decode as a no-op.

`timescale 1ns/1ps

module controlDecoder (
    input  decodePkg::instr_t  instr_i,
    output decodePkg::immFmt_t immFmt_o,
    output decodePkg::aluOp_t  aluOp_o,
    output logic               srcA_o,
    output decodePkg::srcB_t   srcB_o,
    output decodePkg::branch_t branch_o,
    output decodePkg::memOp_t  memOp_o,
    output logic               memToReg_o,
    output logic               memWen_o,
    output logic               wen_o,
    output decodePkg::mulOp_t  mulOp_o,
    output logic               ecall_o,
    output logic               mret_o,
    output logic               csrWen_o,
    output logic               csrToReg_o,
    output decodePkg::csrOp_t  csrOp_o,
    output logic               illegal_o
);
    import decodePkg::*;

    logic [6:0] opcode;
    logic [2:0] func3;
    logic [6:0] func7;

    assign opcode = instr_i[6:0];
    assign func3  = instr_i[14:12];
    assign func7  = instr_i[31:25];

    always_comb begin
        immFmt_o   = fmtI;
        aluOp_o    = aluAdd;
        srcA_o     = 1'b1;      // rs1 unless the opcode needs pc.
        srcB_o     = srcBImm;
        branch_o   = brNone;
        memOp_o    = func3;
        memToReg_o = 1'b0;
        memWen_o   = 1'b0;
        wen_o      = 1'b0;
        mulOp_o    = func3[1:0];
        ecall_o    = 1'b0;
        mret_o     = 1'b0;
        csrWen_o   = 1'b0;
        csrToReg_o = 1'b0;
        csrOp_o    = func3;
        illegal_o  = 1'b0;

        case (opcode)
            opLui: begin
                immFmt_o = fmtU;
                aluOp_o  = aluCopyB;
                wen_o    = 1'b1;
            end
            opAuipc: begin
                immFmt_o = fmtU;
                srcA_o   = 1'b0;
                wen_o    = 1'b1;
            end
            opJal: begin
                immFmt_o = fmtJ;
                srcA_o   = 1'b0;
                srcB_o   = srcBFour;    // the link value is pc+4.
                branch_o = brJal;
                wen_o    = 1'b1;
            end
            opJalr: begin
                srcA_o    = 1'b0;
                srcB_o    = srcBFour;
                branch_o  = brJalr;
                wen_o     = 1'b1;
                illegal_o = (func3 != 3'b000);
            end
            opBranch: begin
                immFmt_o = fmtB;
                aluOp_o  = aluSub;
                srcB_o   = srcBReg;
                case (func3)
                    3'b000:  branch_o = brEq;
                    3'b001:  branch_o = brNe;
                    3'b100:  branch_o = brLt;
                    3'b101:  branch_o = brGe;
                    3'b110:  branch_o = brLtu;
                    3'b111:  branch_o = brGeu;
                    default: illegal_o = 1'b1;
                endcase
            end
            opLoad: begin
                memToReg_o = 1'b1;
                wen_o      = 1'b1;
                illegal_o  = (func3 == 3'b111);
            end
            opStore: begin
                immFmt_o  = fmtS;
                memWen_o  = 1'b1;
                illegal_o = func3[2];
            end
            opImm: begin
                wen_o = 1'b1;
                case (func3)
                    3'b000: aluOp_o = aluAdd;
                    3'b010: aluOp_o = aluSlt;
                    3'b011: aluOp_o = aluSltu;
                    3'b100: aluOp_o = aluXor;
                    3'b110: aluOp_o = aluOr;
                    3'b111: aluOp_o = aluAnd;
                    3'b001: begin
                        aluOp_o   = aluSll;
                        illegal_o = (instr_i[31:26] != 6'b000000);
                    end
                    default: begin
                        // shift amount is six bits on RV64, bit 30 picks arithmetic.
                        aluOp_o   = instr_i[30] ? aluSra : aluSrl;
                        illegal_o = ({instr_i[31], instr_i[29:26]} != 5'b00000);
                    end
                endcase
            end
            opImm32: begin
                wen_o = 1'b1;
                case (func3)
                    3'b000: aluOp_o = aluAddw;
                    3'b001: begin
                        aluOp_o   = aluSllw;
                        illegal_o = (func7 != 7'b0000000);
                    end
                    3'b101: begin
                        aluOp_o   = instr_i[30] ? aluSraw : aluSrlw;
                        illegal_o = ({func7[6], func7[4:0]} != 6'b000000);
                    end
                    default: illegal_o = 1'b1;
                endcase
            end
            opReg: begin
                srcB_o = srcBReg;
                wen_o  = 1'b1;
                case (func7)
                    7'b0000000: begin
                        case (func3)
                            3'b000:  aluOp_o = aluAdd;
                            3'b001:  aluOp_o = aluSll;
                            3'b010:  aluOp_o = aluSlt;
                            3'b011:  aluOp_o = aluSltu;
                            3'b100:  aluOp_o = aluXor;
                            3'b101:  aluOp_o = aluSrl;
                            3'b110:  aluOp_o = aluOr;
                            default: aluOp_o = aluAnd;
                        endcase
                    end
                    7'b0100000: begin
                        aluOp_o   = func3[2] ? aluSra : aluSub;
                        illegal_o = (func3 != 3'b000) && (func3 != 3'b101);
                    end
                    7'b0000001: begin
                        aluOp_o   = aluMul;     // divides are not decoded.
                        illegal_o = func3[2];
                    end
                    default: illegal_o = 1'b1;
                endcase
            end
            opReg32: begin
                srcB_o = srcBReg;
                wen_o  = 1'b1;
                case ({func7, func3})
                    10'b0000000_000: aluOp_o = aluAddw;
                    10'b0000000_001: aluOp_o = aluSllw;
                    10'b0000000_101: aluOp_o = aluSrlw;
                    10'b0100000_000: aluOp_o = aluSubw;
                    10'b0100000_101: aluOp_o = aluSraw;
                    10'b0000001_000: aluOp_o = aluMulw;
                    default:         illegal_o = 1'b1;
                endcase
            end
            opSystem: begin
                if (func3 == 3'b000) begin
                    // rd and rs1 are zero in both ECALL and MRET.
                    ecall_o   = (instr_i[31:7] == 25'b0);
                    mret_o    = (instr_i[31:7] == {12'h302, 13'b0});
                    csrWen_o  = ecall_o;    // ecall records the trap cause.
                    csrOp_o   = csrOpWrite;
                    illegal_o = !(ecall_o || mret_o);
                end else begin
                    csrWen_o   = 1'b1;
                    csrToReg_o = 1'b1;
                    wen_o      = 1'b1;
                    illegal_o  = (func3 == 3'b100);
                end
            end
            default: illegal_o = 1'b1;
        endcase

        // an illegal word must not write anything or redirect the pc.
        if (illegal_o) begin
            branch_o   = brNone;
            memToReg_o = 1'b0;
            memWen_o   = 1'b0;
            wen_o      = 1'b0;
            ecall_o    = 1'b0;
            mret_o     = 1'b0;
            csrWen_o   = 1'b0;
            csrToReg_o = 1'b0;
        end
    end

endmodule

/* hw/immGen.sv */
// Immediate generator.
// Gathers the immediate bits of the I, S, B, U and J formats and sign-extends
// them to 64 bits.

`timescale 1ns/1ps

module immGen (
    input  decodePkg::instr_t  instr_i,
    input  decodePkg::immFmt_t immFmt_i,
    output decodePkg::xlen_t   imm_o
);
    import decodePkg::*;

    logic sign;

    assign sign = instr_i[31];  // every format keeps its sign in bit 31.

    always_comb begin
        case (immFmt_i)
            fmtS:    imm_o = {{53{sign}}, instr_i[30:25], instr_i[11:7]};
            fmtB:    imm_o = {{52{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            fmtU:    imm_o = {{32{sign}}, instr_i[31:12], 12'b0};
            fmtJ:    imm_o = {{44{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            default: imm_o = {{53{sign}}, instr_i[30:20]};
        endcase
    end

endmodule

/* hw/nextPcUnit.sv */
// Next-PC unit.
// Compares rs1 with rs2 for the conditional branches, forms the jump targets
// and picks the next pc by priority: ecall, mret, jal, jalr, taken branch, pc+4.

`timescale 1ns/1ps

module nextPcUnit (
    input  decodePkg::xlen_t   pc_i,
    input  decodePkg::xlen_t   rs1Data_i,
    input  decodePkg::xlen_t   rs2Data_i,
    input  decodePkg::xlen_t   imm_i,
    input  decodePkg::xlen_t   mtvec_i,
    input  decodePkg::xlen_t   mepc_i,
    input  decodePkg::branch_t branch_i,
    input  logic               ecall_i,
    input  logic               mret_i,
    output decodePkg::xlen_t   dnpc_o
);
    import decodePkg::*;

    logic  isEq;
    logic  isLt;
    logic  isLtu;
    logic  taken;
    xlen_t target;

    // reduced comparison ALU, rs1 against rs2.
    assign isEq  = (rs1Data_i == rs2Data_i);
    assign isLt  = ($signed(rs1Data_i) < $signed(rs2Data_i));
    assign isLtu = (rs1Data_i < rs2Data_i);

    always_comb begin
        case (branch_i)
            brEq:    taken = isEq;
            brNe:    taken = !isEq;
            brLt:    taken = isLt;
            brGe:    taken = !isLt;
            brLtu:   taken = isLtu;
            brGeu:   taken = !isLtu;
            default: taken = 1'b0;      // jumps are handled below.
        endcase
    end

    always_comb begin
        if (ecall_i) begin
            target = mtvec_i;
        end else if (mret_i) begin
            target = mepc_i;
        end else if (branch_i == brJal) begin
            target = pc_i + imm_i;
        end else if (branch_i == brJalr) begin
            target = rs1Data_i + imm_i;
        end else if (taken) begin
            target = pc_i + imm_i;
        end else begin
            target = pc_i + 64'd4;
        end
    end

    assign dnpc_o = {target[63:1], 1'b0};

endmodule

/* hw/decodeStage.sv */
// Instruction-decode stage.
// Decodes one instruction per cycle into register indices, immediate, control
// codes and next pc, applies the ECALL overrides of rs1 and the csr index,
// and registers every result when valid_i is high.

`timescale 1ns/1ps

module decodeStage (
    input  logic               clk_i,
    input  logic               rstN_i,
    input  logic               valid_i,
    input  decodePkg::instr_t  instr_i,
    input  decodePkg::xlen_t   pc_i,
    input  decodePkg::xlen_t   rs1Data_i,
    input  decodePkg::xlen_t   rs2Data_i,
    input  decodePkg::xlen_t   mtvec_i,
    input  decodePkg::xlen_t   mepc_i,
    output logic               valid_o,
    output decodePkg::xlen_t   dnpc_o,
    output decodePkg::regIdx_t rd_o,
    output decodePkg::regIdx_t rs1_o,
    output decodePkg::regIdx_t rs2_o,
    output decodePkg::xlen_t   imm_o,
    output decodePkg::csrIdx_t csrId_o,
    output decodePkg::aluOp_t  aluOp_o,
    output logic               srcA_o,
    output decodePkg::srcB_t   srcB_o,
    output decodePkg::memOp_t  memOp_o,
    output logic               memToReg_o,
    output logic               memWen_o,
    output logic               wen_o,
    output decodePkg::mulOp_t  mulOp_o,
    output logic               ecall_o,
    output logic               mret_o,
    output logic               csrWen_o,
    output logic               csrToReg_o,
    output decodePkg::csrOp_t  csrOp_o,
    output logic               illegal_o
);
    import decodePkg::*;

    immFmt_t immFmt;
    aluOp_t  aluOp;
    logic    srcA;
    srcB_t   srcB;
    branch_t branch;
    memOp_t  memOp;
    logic    memToReg;
    logic    memWen;
    logic    wen;
    mulOp_t  mulOp;
    logic    ecall;
    logic    mret;
    logic    csrWen;
    logic    csrToReg;
    csrOp_t  csrOp;
    logic    illegal;
    xlen_t   imm;
    xlen_t   dnpc;
    regIdx_t rs1Idx;
    csrIdx_t csrIdx;

    controlDecoder uControl (
        .instr_i    (instr_i),
        .immFmt_o   (immFmt),
        .aluOp_o    (aluOp),
        .srcA_o     (srcA),
        .srcB_o     (srcB),
        .branch_o   (branch),
        .memOp_o    (memOp),
        .memToReg_o (memToReg),
        .memWen_o   (memWen),
        .wen_o      (wen),
        .mulOp_o    (mulOp),
        .ecall_o    (ecall),
        .mret_o     (mret),
        .csrWen_o   (csrWen),
        .csrToReg_o (csrToReg),
        .csrOp_o    (csrOp),
        .illegal_o  (illegal)
    );

    immGen uImm (
        .instr_i  (instr_i),
        .immFmt_i (immFmt),
        .imm_o    (imm)
    );

    nextPcUnit uNextPc (
        .pc_i      (pc_i),
        .rs1Data_i (rs1Data_i),
        .rs2Data_i (rs2Data_i),
        .imm_i     (imm),
        .mtvec_i   (mtvec_i),
        .mepc_i    (mepc_i),
        .branch_i  (branch),
        .ecall_i   (ecall),
        .mret_i    (mret),
        .dnpc_o    (dnpc)
    );

    // ecall reads a7 and writes mcause.
    assign rs1Idx = ecall ? ecallArgReg : instr_i[19:15];
    assign csrIdx = ecall ? csrMcause : instr_i[31:20];

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            valid_o   <= 1'b0;
            wen_o     <= 1'b0;
            memWen_o  <= 1'b0;
            csrWen_o  <= 1'b0;
            ecall_o   <= 1'b0;
            mret_o    <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                wen_o     <= wen;
                memWen_o  <= memWen;
                csrWen_o  <= csrWen;
                ecall_o   <= ecall;
                mret_o    <= mret;
                illegal_o <= illegal;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            dnpc_o     <= dnpc;
            rd_o       <= instr_i[11:7];
            rs1_o      <= rs1Idx;
            rs2_o      <= instr_i[24:20];
            imm_o      <= imm;
            csrId_o    <= csrIdx;
            aluOp_o    <= aluOp;
            srcA_o     <= srcA;
            srcB_o     <= srcB;
            memOp_o    <= memOp;
            memToReg_o <= memToReg;
            mulOp_o    <= mulOp;
            csrToReg_o <= csrToReg;
            csrOp_o    <= csrOp;
        end
    end

    // an illegal word reaches the later stages with every write enable low.
    assert property (@(posedge clk_i) disable iff (!rstN_i)
                     valid_o && illegal_o |-> !(wen_o || memWen_o || csrWen_o))
        else $error("illegal instruction left with a write enable set");

endmodule

/* include/decodeVectors.svh */
// Decode-stage test vectors.
// One row per test: the instruction and operands that enter the stage and the
// next pc, register indices, immediate, flags and control codes expected out of it.
// Columns: name, instr, pc, rs1Data, rs2Data, dnpc, rd, rs1, imm, flags, csrId,
// backToBack, rs2, aluOp, srcB, memOp, mulOp, csrOp, ctrl.
// flags are {wen, memWen, csrWen, illegal}, ctrl is {srcA, memToReg, ecall, mret, csrToReg}.

`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct packed {
    instr_t       instr;
    xlen_t        pc;
    xlen_t        rs1Data;
    xlen_t        rs2Data;
    xlen_t        dnpc;
    regIdx_t      rd;
    regIdx_t      rs1;
    xlen_t        imm;
    logic [3:0]   flags;
    csrIdx_t      csrId;
    logic         backToBack;   // issued in the cycle right after the previous row.
    regIdx_t      rs2;
    aluOp_t       aluOp;
    srcB_t        srcB;
    memOp_t       memOp;
    mulOp_t       mulOp;
    csrOp_t       csrOp;
    logic [4:0]   ctrl;
} row_t;

localparam xlen_t basePc  = 64'h0000_0000_8000_1000;
localparam xlen_t trapVec = 64'h0000_0000_8000_0400;
localparam xlen_t retPc   = 64'h0000_0000_8000_2468;
localparam xlen_t negOne  = 64'hFFFF_FFFF_FFFF_FFFF;

task automatic buildTable();
    addRow("addiPos", 32'h06430293, basePc, 64'd0, 64'd0, basePc + 64'd4,
           5'd5, 5'd6, 64'h64, 4'b1000, 12'h064, 1'b0,
           5'd4, aluAdd, srcBImm, 3'd0, 2'd0, 3'd0, 5'b10000);
    addRow("addiNeg", 32'hFFF10093, basePc, 64'd0, 64'd0, basePc + 64'd4,
           5'd1, 5'd2, negOne, 4'b1000, 12'hFFF, 1'b1,
           5'd31, aluAdd, srcBImm, 3'd0, 2'd0, 3'd0, 5'b10000);
    addRow("addiMin", 32'h80058513, basePc, 64'd0, 64'd0, basePc + 64'd4,
           5'd10, 5'd11, 64'hFFFF_FFFF_FFFF_F800, 4'b1000, 12'h800, 1'b1,
           5'd0, aluAdd, srcBImm, 3'd0, 2'd0, 3'd0, 5'b10000);
    addRow("ld", 32'h0104B403, basePc, 64'd0, 64'd0, basePc + 64'd4,
           5'd8, 5'd9, 64'h10, 4'b1000, 12'h010, 1'b0,
           5'd16, aluAdd, srcBImm, 3'd3, 2'd3, 3'd3, 5'b11000);
    addRow("sd", 32'hFE713C23, basePc, 64'd0, 64'd0, basePc + 64'd4,
           5'd24, 5'd2, 64'hFFFF_FFFF_FFFF_FFF8, 4'b0100, 12'hFE7, 1'b1,
           5'd7, aluAdd, srcBImm, 3'd3, 2'd3, 3'd3, 5'b10000);
    addRow("lui", 32'h123451B7, basePc, 64'd0, 64'd0, basePc + 64'd4,
           5'd3, 5'd8, 64'h1234_5000, 4'b1000, 12'h123, 1'b0,
           5'd3, aluCopyB, srcBImm, 3'd5, 2'd1, 3'd5, 5'b10000);
    addRow("auipcNeg", 32'h80000217, basePc, 64'd0, 64'd0, basePc + 64'd4,
           5'd4, 5'd0, 64'hFFFF_FFFF_8000_0000, 4'b1000, 12'h800, 1'b1,
           5'd0, aluAdd, srcBImm, 3'd0, 2'd0, 3'd0, 5'b00000);
    addRow("jalFwd", 32'h100000EF, basePc, 64'd0, 64'd0, basePc + 64'h100,
           5'd1, 5'd0, 64'h100, 4'b1000, 12'h100, 1'b0,
           5'd0, aluAdd, srcBFour, 3'd0, 2'd0, 3'd0, 5'b00000);
    addRow("jalBack", 32'hFF9FF06F, basePc, 64'd0, 64'd0, basePc - 64'd8,
           5'd0, 5'd31, 64'hFFFF_FFFF_FFFF_FFF8, 4'b1000, 12'hFF9, 1'b1,
           5'd25, aluAdd, srcBFour, 3'd7, 2'd3, 3'd7, 5'b00000);
    // rs1 + 3 is odd, so bit 0 of the target drops.
    addRow("jalrOdd", 32'h003280E7, basePc, 64'h8000_2000, 64'd0, 64'h8000_2002,
           5'd1, 5'd5, 64'h3, 4'b1000, 12'h003, 1'b0,
           5'd3, aluAdd, srcBFour, 3'd0, 2'd0, 3'd0, 5'b00000);
    addRow("beqTaken", 32'h00B50863, basePc, 64'd5, 64'd5, basePc + 64'd16,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b0,
           5'd11, aluSub, srcBReg, 3'd0, 2'd0, 3'd0, 5'b10000);
    addRow("beqNot", 32'h00B50863, basePc, 64'd5, 64'd6, basePc + 64'd4,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b1,
           5'd11, aluSub, srcBReg, 3'd0, 2'd0, 3'd0, 5'b10000);
    addRow("bneTaken", 32'h00B51863, basePc, 64'd5, 64'd6, basePc + 64'd16,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b1,
           5'd11, aluSub, srcBReg, 3'd1, 2'd1, 3'd1, 5'b10000);
    addRow("bneNot", 32'h00B51863, basePc, 64'd5, 64'd5, basePc + 64'd4,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b1,
           5'd11, aluSub, srcBReg, 3'd1, 2'd1, 3'd1, 5'b10000);
    addRow("bltTaken", 32'h00B54863, basePc, negOne, 64'd1, basePc + 64'd16,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b1,
           5'd11, aluSub, srcBReg, 3'd4, 2'd0, 3'd4, 5'b10000);
    addRow("bltNot", 32'h00B54863, basePc, 64'd1, negOne, basePc + 64'd4,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b1,
           5'd11, aluSub, srcBReg, 3'd4, 2'd0, 3'd4, 5'b10000);
    addRow("bgeTaken", 32'h00B55863, basePc, 64'd1, negOne, basePc + 64'd16,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b0,
           5'd11, aluSub, srcBReg, 3'd5, 2'd1, 3'd5, 5'b10000);
    addRow("bgeNot", 32'h00B55863, basePc, negOne, 64'd1, basePc + 64'd4,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b1,
           5'd11, aluSub, srcBReg, 3'd5, 2'd1, 3'd5, 5'b10000);
    addRow("bltuTaken", 32'h00B56863, basePc, 64'd1, negOne, basePc + 64'd16,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b1,
           5'd11, aluSub, srcBReg, 3'd6, 2'd2, 3'd6, 5'b10000);
    addRow("bltuNot", 32'h00B56863, basePc, negOne, 64'd1, basePc + 64'd4,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b1,
           5'd11, aluSub, srcBReg, 3'd6, 2'd2, 3'd6, 5'b10000);
    addRow("bgeuTaken", 32'h00B57863, basePc, negOne, 64'd1, basePc + 64'd16,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b0,
           5'd11, aluSub, srcBReg, 3'd7, 2'd3, 3'd7, 5'b10000);
    addRow("bgeuNot", 32'h00B57863, basePc, 64'd1, negOne, basePc + 64'd4,
           5'd16, 5'd10, 64'h10, 4'b0000, 12'h00B, 1'b1,
           5'd11, aluSub, srcBReg, 3'd7, 2'd3, 3'd7, 5'b10000);
    addRow("ecall", 32'h00000073, basePc, 64'd0, 64'd0, trapVec,
           5'd0, 5'd17, 64'h0, 4'b0010, 12'h342, 1'b0,
           5'd0, aluAdd, srcBImm, 3'd0, 2'd0, 3'd1, 5'b10100);
    addRow("mret", 32'h30200073, basePc, 64'd0, 64'd0, retPc,
           5'd0, 5'd0, 64'h302, 4'b0000, 12'h302, 1'b1,
           5'd2, aluAdd, srcBImm, 3'd0, 2'd0, 3'd1, 5'b10010);
    addRow("csrrw", 32'h340312F3, basePc, 64'd0, 64'd0, basePc + 64'd4,
           5'd5, 5'd6, 64'h340, 4'b1010, 12'h340, 1'b0,
           5'd0, aluAdd, srcBImm, 3'd1, 2'd1, 3'd1, 5'b10001);
    addRow("illegal", 32'h1234567F, basePc, 64'd0, 64'd0, basePc + 64'd4,
           5'd12, 5'd8, 64'h123, 4'b0001, 12'h123, 1'b1,
           5'd3, aluAdd, srcBImm, 3'd5, 2'd1, 3'd5, 5'b10000);
endtask

`endif

/* verification/decodeStageTb.sv */
// Testbench for the decode stage.
// Streams the vector table through the DUT with random idle gaps and some
// back-to-back rows, and checks the registered outputs one cycle later.

`timescale 1ns/1ps

module decodeStageTb;
    import decodePkg::*;

    `include "decodeVectors.svh"

    logic    clk;
    logic    rstN;
    logic    validIn;
    instr_t  instr;
    xlen_t   pc;
    xlen_t   rs1Data;
    xlen_t   rs2Data;
    xlen_t   mtvec;
    xlen_t   mepc;
    logic    validOut;
    xlen_t   dnpc;
    regIdx_t rd;
    regIdx_t rs1;
    regIdx_t rs2;
    xlen_t   imm;
    csrIdx_t csrId;
    aluOp_t  aluOp;
    logic    srcA;
    srcB_t   srcB;
    memOp_t  memOp;
    logic    memToReg;
    mulOp_t  mulOp;
    logic    ecall;
    logic    mret;
    logic    csrToReg;
    csrOp_t  csrOp;
    logic    wen;
    logic    memWen;
    logic    csrWen;
    logic    illegal;

    row_t    rows[$];
    string   names[$];
    int      seed;
    int      runCount;
    int      passCount;
    int      failCount;
    logic    rowOk;
    logic    timedOut;

    decodeStage dut (
        .clk_i (clk), .rstN_i (rstN), .valid_i (validIn), .instr_i (instr),
        .pc_i (pc), .rs1Data_i (rs1Data), .rs2Data_i (rs2Data),
        .mtvec_i (mtvec), .mepc_i (mepc),
        .valid_o (validOut), .dnpc_o (dnpc), .rd_o (rd), .rs1_o (rs1), .rs2_o (rs2),
        .imm_o (imm), .csrId_o (csrId), .aluOp_o (aluOp), .srcA_o (srcA), .srcB_o (srcB),
        .memOp_o (memOp), .memToReg_o (memToReg), .memWen_o (memWen), .wen_o (wen),
        .mulOp_o (mulOp), .ecall_o (ecall), .mret_o (mret), .csrWen_o (csrWen),
        .csrToReg_o (csrToReg), .csrOp_o (csrOp), .illegal_o (illegal)
    );

    always #20 clk = ~clk;

    task automatic addRow(input string name, input instr_t rowInstr, input xlen_t rowPc,
                          input xlen_t rowRs1Data, input xlen_t rowRs2Data,
                          input xlen_t rowDnpc, input regIdx_t rowRd, input regIdx_t rowRs1,
                          input xlen_t rowImm, input logic [3:0] rowFlags,
                          input csrIdx_t rowCsrId, input logic rowBackToBack,
                          input regIdx_t rowRs2, input aluOp_t rowAluOp,
                          input srcB_t rowSrcB, input memOp_t rowMemOp,
                          input mulOp_t rowMulOp, input csrOp_t rowCsrOp,
                          input logic [4:0] rowCtrl);
        row_t r;
        r.instr      = rowInstr;
        r.pc         = rowPc;
        r.rs1Data    = rowRs1Data;
        r.rs2Data    = rowRs2Data;
        r.dnpc       = rowDnpc;
        r.rd         = rowRd;
        r.rs1        = rowRs1;
        r.imm        = rowImm;
        r.flags      = rowFlags;
        r.csrId      = rowCsrId;
        r.backToBack = rowBackToBack;
        r.rs2        = rowRs2;
        r.aluOp      = rowAluOp;
        r.srcB       = rowSrcB;
        r.memOp      = rowMemOp;
        r.mulOp      = rowMulOp;
        r.csrOp      = rowCsrOp;
        r.ctrl       = rowCtrl;
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic compareField(input string name, input string field,
                                input logic [63:0] expected, input logic [63:0] actual);
        assert (actual === expected)
        else begin
            $display("mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
            rowOk = 1'b0;
        end
    endtask

    task automatic driveRow(input row_t r);
        validIn = 1'b1;
        instr   = r.instr;
        pc      = r.pc;
        rs1Data = r.rs1Data;
        rs2Data = r.rs2Data;
    endtask

    // the inputs change while valid_i is low, so a stage that ignores valid_i shows up.
    task automatic driveIdle();
        validIn = 1'b0;
        instr   = 32'h0000_0013;
        pc      = ~pc;
        rs1Data = ~rs1Data;
        rs2Data = ~rs2Data;
    endtask

    task automatic verifyRow(input row_t r, input string name);
        compareField(name, "dnpc", r.dnpc, dnpc);
        compareField(name, "rd", 64'(r.rd), 64'(rd));
        compareField(name, "rs1", 64'(r.rs1), 64'(rs1));
        compareField(name, "rs2", 64'(r.rs2), 64'(rs2));
        compareField(name, "imm", r.imm, imm);
        compareField(name, "wen", 64'(r.flags[3]), 64'(wen));
        compareField(name, "memWen", 64'(r.flags[2]), 64'(memWen));
        compareField(name, "csrWen", 64'(r.flags[1]), 64'(csrWen));
        compareField(name, "illegal", 64'(r.flags[0]), 64'(illegal));
        compareField(name, "csrId", 64'(r.csrId), 64'(csrId));
        compareField(name, "aluOp", 64'(r.aluOp), 64'(aluOp));
        compareField(name, "srcA", 64'(r.ctrl[4]), 64'(srcA));
        compareField(name, "srcB", 64'(r.srcB), 64'(srcB));
        compareField(name, "memOp", 64'(r.memOp), 64'(memOp));
        compareField(name, "memToReg", 64'(r.ctrl[3]), 64'(memToReg));
        compareField(name, "mulOp", 64'(r.mulOp), 64'(mulOp));
        compareField(name, "ecall", 64'(r.ctrl[2]), 64'(ecall));
        compareField(name, "mret", 64'(r.ctrl[1]), 64'(mret));
        compareField(name, "csrToReg", 64'(r.ctrl[0]), 64'(csrToReg));
        compareField(name, "csrOp", 64'(r.csrOp), 64'(csrOp));
    endtask

    // with valid_i low the stage drops valid_o and holds its data.
    task automatic idleCycle(input string name, input xlen_t heldDnpc);
        @(posedge clk);
        #1;
        assert (!validOut)
        else begin
            $display("valid_o stayed high in an idle cycle after %s", name);
            rowOk = 1'b0;
        end
        compareField(name, "heldDnpc", heldDnpc, dnpc);
    endtask

    task automatic closeTest(input string name);
        runCount++;
        if (rowOk) begin
            passCount++;
            $display("test %s: ok", name);
        end else begin
            failCount++;
            $display("test %s: FAILED", name);
        end
    endtask

    initial begin
        int i;
        int gap;
        int cycles;
        clk       = 1'b0;
        rstN      = 1'b0;
        validIn   = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1Data   = '0;
        rs2Data   = '0;
        mtvec     = trapVec;
        mepc      = retPc;
        seed      = 32'h64201350;
        runCount  = 0;
        passCount = 0;
        failCount = 0;
        timedOut  = 1'b0;
        buildTable();

        rowOk = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rstN = 1'b1;
        repeat (2) begin
            @(posedge clk);
            #1;
            compareField("reset", "valid", 64'd0, 64'(validOut));
            compareField("reset", "wen", 64'd0, 64'(wen));
            compareField("reset", "memWen", 64'd0, 64'(memWen));
        end
        closeTest("reset");

        for (i = 0; i < rows.size() && !timedOut; i++) begin
            rowOk = 1'b1;
            if (i > 0 && !rows[i].backToBack) begin
                driveIdle();
                gap = $random(seed) & 3;
                repeat (gap) idleCycle(names[i - 1], rows[i - 1].dnpc);
            end
            driveRow(rows[i]);
            cycles = 0;
            do begin
                @(posedge clk);
                #1;
                cycles++;
            end while (!validOut && cycles < 10);
            if (!validOut) begin
                $display("timeout: valid_o never rose for %s", names[i]);
                timedOut = 1'b1;
                rowOk = 1'b0;
            end else begin
                assert (cycles == 1)
                else begin
                    $display("%s came out after %0d cycles instead of 1", names[i], cycles);
                    rowOk = 1'b0;
                end
                verifyRow(rows[i], names[i]);
            end
            closeTest(names[i]);
        end
        validIn = 1'b0;

        $display("tests: %0d run, %0d passed, %0d failed", runCount, passCount, failCount);
        if (failCount == 0 && !timedOut) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
hw/decodePkg.sv
hw/controlDecoder.sv
hw/immGen.sv
hw/nextPcUnit.sv
hw/decodeStage.sv
verification/decodeStageTb.sv

/* Makefile */
TOP := decodeStageTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

lint:
	verilator --lint-only -Wall --top-module decodeStage \
		hw/decodePkg.sv hw/controlDecoder.sv hw/immGen.sv \
		hw/nextPcUnit.sv hw/decodeStage.sv

clean:
	rm -rf obj_dir
